//--- hw/sdram_bridge_pkg.sv
/*
 * shared widths, depths and FSM encodings for the SDRAM burst bridge
 * burst length is 1..64 words, a length of 0 is not legal on any port
 * FIFO depths must stay powers of two
 */
`default_nettype none

package sdram_bridge_pkg;

	// ------------------------------------------------------------------
	// data path sizes
	// ------------------------------------------------------------------
	localparam int unsigned ADDR_W    = 24;              // sdram word address
	localparam int unsigned DATA_W    = 16;              // one data word
	localparam int unsigned LEN_W     = 7;               // holds 1..64
	localparam int unsigned CMD_W     = ADDR_W + LEN_W;  // address plus length
	localparam int unsigned MAX_BURST = 64;

	// buffer depths
	localparam int unsigned TX_DEPTH  = 128;  // two full bursts of write data
	localparam int unsigned CMD_DEPTH = 8;    // queued write commands
	localparam int unsigned RX_DEPTH  = 64;   // exactly one read burst

	// ------------------------------------------------------------------
	// FSM states
	// ------------------------------------------------------------------
	typedef enum logic [1:0] {
		IDLE   = 2'b00,
		ACCESS = 2'b01,  // write request held until ack
		TRANS  = 2'b11   // streaming burst words out
	} burst_state_e;

	typedef enum logic [1:0] {
		RD_IDLE   = 2'b00,
		RD_ACCESS = 2'b01,  // read request held until ack
		RD_FILL   = 2'b11,  // collecting words into rx fifo
		RD_DRAIN  = 2'b10   // handing the burst to the user
	} rd_state_e;

endpackage

`default_nettype wire

//--- hw/sync_fifo.sv
/*
 * single clock first-word-fall-through FIFO, head word shows on rdata_o
 * DEPTH must be a power of two so the pointers wrap on their own
 * push on full and pop on empty are not guarded here
 */
`default_nettype none

module sync_fifo #(
	parameter int unsigned WIDTH = 16,
	parameter int unsigned DEPTH = 16
) (
	input  wire                         sys_clk,
	input  wire                         sys_rst_n,
	input  wire                         push_i,
	input  wire                         pop_i,
	input  wire  [WIDTH-1:0]            wdata_i,
	output logic [WIDTH-1:0]            rdata_o,
	output logic                        empty_o,
	output logic                        full_o,
	output logic [$clog2(DEPTH+1)-1:0]  count_o
);

	logic [WIDTH-1:0]          mem [DEPTH];       // storage, no reset
	logic [$clog2(DEPTH)-1:0]  wr_ptr;
	logic [$clog2(DEPTH)-1:0]  rd_ptr;
	logic [$clog2(DEPTH+1)-1:0] fill;             // occupancy

	// ------------------------------------------------------------------
	// pointers and occupancy
	// ------------------------------------------------------------------
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill   <= '0;
		end else begin
			if (push_i)
				wr_ptr <= wr_ptr + 1'b1;  // wraps at DEPTH
			if (pop_i)
				rd_ptr <= rd_ptr + 1'b1;
			// both at once leaves the count alone
			if (push_i && !pop_i)
				fill <= fill + 1'b1;
			else if (pop_i && !push_i)
				fill <= fill - 1'b1;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (push_i)
			mem[wr_ptr] <= wdata_i;
	end

	assign rdata_o = mem[rd_ptr];  // fall-through head
	assign empty_o = (fill == '0);
	assign full_o  = (fill == DEPTH);
	assign count_o = fill;

endmodule

`default_nettype wire

//--- hw/wr_burst_engine.sv
/*
 * user write bursts in, SDRAM write request/ack sequence out
 * a command is queued only once all of its words sit in the tx fifo
 * wr_rdy_o needs room for a full 64 word burst, so short bursts waste room
 */
`default_nettype none

module wr_burst_engine
	import sdram_bridge_pkg::*;
(
	input  wire                 sys_clk,
	input  wire                 sys_rst_n,
	input  wire                 init_end_i,
	// user side
	input  wire                 wr_req_i,
	input  wire  [ADDR_W-1:0]   wr_addr_i,
	input  wire  [LEN_W-1:0]    wr_len_i,
	input  wire  [DATA_W-1:0]   wr_data_i,
	output logic                wr_rdy_o,
	// sdram side
	input  wire                 sdram_wr_ack_i,
	output logic                sdram_wr_req_o,
	output logic [ADDR_W-1:0]   sdram_wr_addr_o,
	output logic [LEN_W-1:0]    sdram_wr_len_o,
	output logic [DATA_W-1:0]   sdram_wr_data_o
);

	// capture side
	logic                              cap_busy;   // taking the trailing beats
	logic [LEN_W-1:0]                  cap_cnt;    // beats taken so far
	logic [ADDR_W-1:0]                 cap_addr;
	logic [LEN_W-1:0]                  cap_len;
	logic                              take_acc;   // accept edge, beat 0
	logic                              take_beat;  // beats 1..len-1
	logic                              cap_last;
	// fifo hookup
	logic                              tx_push;
	logic                              tx_pop;
	logic [DATA_W-1:0]                 tx_rdata;
	logic [$clog2(TX_DEPTH+1)-1:0]     tx_count;
	logic                              cmd_push;
	logic                              cmd_pop;
	logic [CMD_W-1:0]                  cmd_wdata;
	logic [CMD_W-1:0]                  cmd_rdata;
	logic                              cmd_empty;
	logic                              cmd_full;
	// sdram side
	burst_state_e                      wr_state;
	logic [LEN_W-1:0]                  beat_cnt;
	logic [ADDR_W-1:0]                 burst_addr;
	logic [LEN_W-1:0]                  burst_len;

	// ------------------------------------------------------------------
	// user capture
	// ------------------------------------------------------------------
	assign wr_rdy_o  = init_end_i && !cap_busy && !cmd_full &&
	                   (tx_count <= TX_DEPTH - MAX_BURST);  // room for a max burst
	assign take_acc  = wr_req_i && wr_rdy_o;
	assign take_beat = cap_busy && (cap_cnt != cap_len);
	assign cap_last  = (cap_cnt + 1'b1 == cap_len);

	assign tx_push   = take_acc || take_beat;
	// single word burst queues its command right at acceptance
	assign cmd_push  = (take_acc && (wr_len_i == LEN_W'(1))) || (take_beat && cap_last);
	assign cmd_wdata = take_acc ? {wr_addr_i, wr_len_i} : {cap_addr, cap_len};

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			cap_busy <= 1'b0;
			cap_cnt  <= '0;
		end else if (take_acc) begin
			cap_busy <= 1'b1;  // always one busy cycle, even for len 1
			cap_cnt  <= LEN_W'(1);
		end else if (cap_busy) begin
			if (take_beat)
				cap_cnt <= cap_cnt + 1'b1;
			if (!take_beat || cap_last)
				cap_busy <= 1'b0;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (take_acc) begin
			cap_addr <= wr_addr_i;
			cap_len  <= wr_len_i;
		end
	end

	// ------------------------------------------------------------------
	// sdram write sequence
	// ------------------------------------------------------------------
	assign cmd_pop = (wr_state == IDLE) && !cmd_empty;
	assign tx_pop  = (wr_state == TRANS);  // one word per edge after ack

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			wr_state <= IDLE;
			beat_cnt <= '0;
		end else begin
			case (wr_state)
				IDLE: begin
					if (!cmd_empty)
						wr_state <= ACCESS;
				end
				ACCESS: begin
					if (sdram_wr_ack_i) begin
						wr_state <= TRANS;
						beat_cnt <= '0;
					end
				end
				TRANS: begin
					if (beat_cnt == burst_len - 1'b1)
						wr_state <= IDLE;  // forces the idle gap
					else
						beat_cnt <= beat_cnt + 1'b1;
				end
				default: wr_state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (cmd_pop)
			{burst_addr, burst_len} <= cmd_rdata;
	end

	assign sdram_wr_req_o  = (wr_state == ACCESS);
	assign sdram_wr_addr_o = (wr_state == ACCESS) ? burst_addr : '0;
	assign sdram_wr_len_o  = (wr_state == ACCESS) ? burst_len : '0;
	assign sdram_wr_data_o = tx_rdata;  // head word, valid in TRANS

	// ------------------------------------------------------------------
	// buffers
	// ------------------------------------------------------------------
	sync_fifo #(
		.WIDTH (DATA_W),
		.DEPTH (TX_DEPTH)
	) u_tx_fifo (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.push_i    (tx_push),
		.pop_i     (tx_pop),
		.wdata_i   (wr_data_i),
		.rdata_o   (tx_rdata),
		.empty_o   (),
		.full_o    (),
		.count_o   (tx_count)
	);

	sync_fifo #(
		.WIDTH (CMD_W),
		.DEPTH (CMD_DEPTH)
	) u_cmd_fifo (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.push_i    (cmd_push),
		.pop_i     (cmd_pop),
		.wdata_i   (cmd_wdata),
		.rdata_o   (cmd_rdata),
		.empty_o   (cmd_empty),
		.full_o    (cmd_full),
		.count_o   ()
	);

endmodule

`default_nettype wire

//--- hw/rd_burst_engine.sv
/*
 * one read burst in flight at a time, the user waits on rd_rdy_o
 * the whole burst lands in the rx fifo before rd_valid_o starts
 * the user side has no back-pressure
 */
`default_nettype none

module rd_burst_engine
	import sdram_bridge_pkg::*;
(
	input  wire                 sys_clk,
	input  wire                 sys_rst_n,
	input  wire                 init_end_i,
	// user side
	input  wire                 rd_req_i,
	input  wire  [ADDR_W-1:0]   rd_addr_i,
	input  wire  [LEN_W-1:0]    rd_len_i,
	output logic                rd_rdy_o,
	output logic                rd_valid_o,
	output logic [DATA_W-1:0]   rd_data_o,
	// sdram side
	input  wire                 sdram_rd_ack_i,
	input  wire                 sdram_rd_valid_i,
	input  wire  [DATA_W-1:0]   sdram_rd_data_i,
	output logic                sdram_rd_req_o,
	output logic [ADDR_W-1:0]   sdram_rd_addr_o,
	output logic [LEN_W-1:0]    sdram_rd_len_o
);

	rd_state_e           rd_state;
	logic [LEN_W-1:0]    beat_cnt;    // words in during fill, words out during drain
	logic [ADDR_W-1:0]   burst_addr;
	logic [LEN_W-1:0]    burst_len;
	logic                accept;
	logic                rx_push;
	logic                rx_pop;
	logic                rx_done;     // this edge pushes the last word

	assign rd_rdy_o = init_end_i && (rd_state == RD_IDLE);
	assign accept   = rd_req_i && rd_rdy_o;

	// data may already flow while the ack is pending
	assign rx_push = sdram_rd_valid_i && ((rd_state == RD_ACCESS) || (rd_state == RD_FILL));
	assign rx_done = rx_push && (beat_cnt + 1'b1 == burst_len);
	assign rx_pop  = (rd_state == RD_DRAIN);

	// ------------------------------------------------------------------
	// read FSM
	// ------------------------------------------------------------------
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rd_state <= RD_IDLE;
			beat_cnt <= '0;
		end else begin
			case (rd_state)
				RD_IDLE: begin
					if (accept) begin
						rd_state <= RD_ACCESS;
						beat_cnt <= '0;
					end
				end
				RD_ACCESS: begin
					if (rx_done) begin
						rd_state <= RD_DRAIN;  // burst complete before ack, unusual
						beat_cnt <= '0;
					end else begin
						if (sdram_rd_ack_i)
							rd_state <= RD_FILL;
						if (rx_push)
							beat_cnt <= beat_cnt + 1'b1;
					end
				end
				RD_FILL: begin
					if (rx_done) begin
						rd_state <= RD_DRAIN;
						beat_cnt <= '0;  // reused as drain counter
					end else if (rx_push) begin
						beat_cnt <= beat_cnt + 1'b1;
					end
				end
				RD_DRAIN: begin
					if (beat_cnt == burst_len - 1'b1)
						rd_state <= RD_IDLE;
					else
						beat_cnt <= beat_cnt + 1'b1;
				end
				default: rd_state <= RD_IDLE;
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (accept) begin
			burst_addr <= rd_addr_i;
			burst_len  <= rd_len_i;
		end
	end

	assign sdram_rd_req_o  = (rd_state == RD_ACCESS);
	assign sdram_rd_addr_o = (rd_state == RD_ACCESS) ? burst_addr : '0;
	assign sdram_rd_len_o  = (rd_state == RD_ACCESS) ? burst_len : '0;
	assign rd_valid_o      = (rd_state == RD_DRAIN);  // len cycles back to back

	// rx buffer, sized for exactly one max burst
	sync_fifo #(
		.WIDTH (DATA_W),
		.DEPTH (RX_DEPTH)
	) u_rx_fifo (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.push_i    (rx_push),
		.pop_i     (rx_pop),
		.wdata_i   (sdram_rd_data_i),
		.rdata_o   (rd_data_o),
		.empty_o   (),
		.full_o    (),
		.count_o   ()
	);

endmodule

`default_nettype wire

//--- hw/sdram_fifo_bridge.sv
/*
 * bridge between a user burst port and an SDRAM controller burst port
 * single clock, writes and reads run independently of each other
 */
`default_nettype none

module sdram_fifo_bridge
	import sdram_bridge_pkg::*;
(
	input  wire                 sys_clk,
	input  wire                 sys_rst_n,
	input  wire                 init_end_i,       // sdram init finished
	// user write port
	input  wire                 wr_req_i,
	input  wire  [ADDR_W-1:0]   wr_addr_i,
	input  wire  [LEN_W-1:0]    wr_len_i,
	input  wire  [DATA_W-1:0]   wr_data_i,
	output logic                wr_rdy_o,
	// user read port
	input  wire                 rd_req_i,
	input  wire  [ADDR_W-1:0]   rd_addr_i,
	input  wire  [LEN_W-1:0]    rd_len_i,
	output logic                rd_rdy_o,
	output logic                rd_valid_o,
	output logic [DATA_W-1:0]   rd_data_o,
	// sdram write port
	input  wire                 sdram_wr_ack_i,
	output logic                sdram_wr_req_o,
	output logic [ADDR_W-1:0]   sdram_wr_addr_o,
	output logic [LEN_W-1:0]    sdram_wr_len_o,
	output logic [DATA_W-1:0]   sdram_wr_data_o,
	// sdram read port
	input  wire                 sdram_rd_ack_i,
	input  wire                 sdram_rd_valid_i,
	input  wire  [DATA_W-1:0]   sdram_rd_data_i,
	output logic                sdram_rd_req_o,
	output logic [ADDR_W-1:0]   sdram_rd_addr_o,
	output logic [LEN_W-1:0]    sdram_rd_len_o
);

	// ------------------------------------------------------------------
	// write path
	// ------------------------------------------------------------------
	wr_burst_engine u_wr_engine (
		.sys_clk         (sys_clk),
		.sys_rst_n       (sys_rst_n),
		.init_end_i      (init_end_i),
		.wr_req_i        (wr_req_i),
		.wr_addr_i       (wr_addr_i),
		.wr_len_i        (wr_len_i),
		.wr_data_i       (wr_data_i),
		.wr_rdy_o        (wr_rdy_o),
		.sdram_wr_ack_i  (sdram_wr_ack_i),
		.sdram_wr_req_o  (sdram_wr_req_o),
		.sdram_wr_addr_o (sdram_wr_addr_o),
		.sdram_wr_len_o  (sdram_wr_len_o),
		.sdram_wr_data_o (sdram_wr_data_o)
	);

	// ------------------------------------------------------------------
	// read path
	// ------------------------------------------------------------------
	rd_burst_engine u_rd_engine (
		.sys_clk          (sys_clk),
		.sys_rst_n        (sys_rst_n),
		.init_end_i       (init_end_i),
		.rd_req_i         (rd_req_i),
		.rd_addr_i        (rd_addr_i),
		.rd_len_i         (rd_len_i),
		.rd_rdy_o         (rd_rdy_o),
		.rd_valid_o       (rd_valid_o),
		.rd_data_o        (rd_data_o),
		.sdram_rd_ack_i   (sdram_rd_ack_i),
		.sdram_rd_valid_i (sdram_rd_valid_i),
		.sdram_rd_data_i  (sdram_rd_data_i),
		.sdram_rd_req_o   (sdram_rd_req_o),
		.sdram_rd_addr_o  (sdram_rd_addr_o),
		.sdram_rd_len_o   (sdram_rd_len_o)
	);

endmodule

`default_nettype wire

//--- tb/sdram_fifo_bridge_checker.sv
/*
 * protocol assertions, bound into the bridge top level
 * fifo misuse is watched through the engine internals
 */
`default_nettype none

module sdram_fifo_bridge_checker
	import sdram_bridge_pkg::*;
(
	input wire                 sys_clk,
	input wire                 sys_rst_n,
	input wire                 init_end_i,
	input wire                 wr_rdy_o,
	input wire                 rd_rdy_o,
	input wire                 rd_valid_o,
	input wire                 sdram_wr_req_o,
	input wire                 sdram_wr_ack_i,
	input wire  [ADDR_W-1:0]   sdram_wr_addr_o,
	input wire  [LEN_W-1:0]    sdram_wr_len_o,
	input wire                 sdram_rd_req_o,
	input wire                 sdram_rd_ack_i,
	input wire  [ADDR_W-1:0]   sdram_rd_addr_o,
	input wire  [LEN_W-1:0]    sdram_rd_len_o,
	input wire                 tx_push,
	input wire                 tx_pop,
	input wire                 tx_full,
	input wire                 tx_empty,
	input wire                 cmd_push,
	input wire                 cmd_pop,
	input wire                 cmd_full,
	input wire                 cmd_empty,
	input wire                 rx_push,
	input wire                 rx_pop,
	input wire                 rx_full,
	input wire                 rx_empty
);
	timeunit 1ns;
	timeprecision 100ps;

	int unsigned fail_cnt = 0;  // read by the testbench at the end

	// ------------------------------------------------------------------
	// SDRAM request/ack
	// ------------------------------------------------------------------
	wr_req_held: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		sdram_wr_req_o && !sdram_wr_ack_i |=>
		sdram_wr_req_o && $stable(sdram_wr_addr_o) && $stable(sdram_wr_len_o))
	else begin
		$error("write request dropped or changed before ack");
		fail_cnt++;
	end

	rd_req_held: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		sdram_rd_req_o && !sdram_rd_ack_i |=>
		sdram_rd_req_o && $stable(sdram_rd_addr_o) && $stable(sdram_rd_len_o))
	else begin
		$error("read request dropped or changed before ack");
		fail_cnt++;
	end

	// user side stays silent until sdram init ends
	quiet_before_init: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!init_end_i |-> !wr_rdy_o && !rd_rdy_o && !rd_valid_o)
	else begin
		$error("user ready or valid high before init_end_i");
		fail_cnt++;
	end

	// ------------------------------------------------------------------
	// fifo use
	// ------------------------------------------------------------------
	tx_fifo_use: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!((tx_push && tx_full) || (tx_pop && tx_empty)))
	else begin
		$error("tx fifo pushed while full or popped while empty");
		fail_cnt++;
	end

	cmd_fifo_use: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!((cmd_push && cmd_full) || (cmd_pop && cmd_empty)))
	else begin
		$error("command fifo pushed while full or popped while empty");
		fail_cnt++;
	end

	rx_fifo_use: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!((rx_push && rx_full) || (rx_pop && rx_empty)))
	else begin
		$error("rx fifo pushed while full or popped while empty");
		fail_cnt++;
	end

	valid_not_during_req: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		rd_valid_o |-> !sdram_rd_req_o)
	else begin
		$error("rd_valid_o high while a read request is pending");
		fail_cnt++;
	end

endmodule

bind sdram_fifo_bridge sdram_fifo_bridge_checker u_chk (
	.*,
	.tx_push   (u_wr_engine.u_tx_fifo.push_i),
	.tx_pop    (u_wr_engine.u_tx_fifo.pop_i),
	.tx_full   (u_wr_engine.u_tx_fifo.full_o),
	.tx_empty  (u_wr_engine.u_tx_fifo.empty_o),
	.cmd_push  (u_wr_engine.u_cmd_fifo.push_i),
	.cmd_pop   (u_wr_engine.u_cmd_fifo.pop_i),
	.cmd_full  (u_wr_engine.u_cmd_fifo.full_o),
	.cmd_empty (u_wr_engine.u_cmd_fifo.empty_o),
	.rx_push   (u_rd_engine.u_rx_fifo.push_i),
	.rx_pop    (u_rd_engine.u_rx_fifo.pop_i),
	.rx_full   (u_rd_engine.u_rx_fifo.full_o),
	.rx_empty  (u_rd_engine.u_rx_fifo.empty_o)
);

`default_nettype wire

//--- tb/sdram_fifo_bridge_tb.sv
/*
 * testbench with a behavioral SDRAM controller model
 * inputs change 10 ns after the rising edge, outputs are looked at there too
 * model acks after 0..6 cycles, read words come back with random gaps
 */
`default_nettype none

module sdram_fifo_bridge_tb
	import sdram_bridge_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int TIMEOUT_CYCLES = 6000;  // roughly 3000 needed, doubled

	logic                sys_clk;
	logic                sys_rst_n;
	logic                init_end_i;
	logic                wr_req_i;
	logic [ADDR_W-1:0]   wr_addr_i;
	logic [LEN_W-1:0]    wr_len_i;
	logic [DATA_W-1:0]   wr_data_i;
	logic                wr_rdy_o;
	logic                rd_req_i;
	logic [ADDR_W-1:0]   rd_addr_i;
	logic [LEN_W-1:0]    rd_len_i;
	logic                rd_rdy_o;
	logic                rd_valid_o;
	logic [DATA_W-1:0]   rd_data_o;
	logic                sdram_wr_ack_i;
	logic                sdram_wr_req_o;
	logic [ADDR_W-1:0]   sdram_wr_addr_o;
	logic [LEN_W-1:0]    sdram_wr_len_o;
	logic [DATA_W-1:0]   sdram_wr_data_o;
	logic                sdram_rd_ack_i;
	logic                sdram_rd_valid_i;
	logic [DATA_W-1:0]   sdram_rd_data_i;
	logic                sdram_rd_req_o;
	logic [ADDR_W-1:0]   sdram_rd_addr_o;
	logic [LEN_W-1:0]    sdram_rd_len_o;

	// model and scoreboard state
	logic [DATA_W-1:0]   sdram_mem [logic [ADDR_W-1:0]];  // what the model holds
	logic [DATA_W-1:0]   ref_mem [logic [ADDR_W-1:0]];    // what the user wrote
	logic [ADDR_W-1:0]   exp_addr_q [$];                  // write commands, acceptance order
	logic [LEN_W-1:0]    exp_len_q [$];
	logic [DATA_W-1:0]   exp_word_q [$];
	logic [ADDR_W-1:0]   rd_exp_addr;
	logic [LEN_W-1:0]    rd_exp_len;
	logic [ADDR_W-1:0]   rnd_addr [10];
	logic [LEN_W-1:0]    rnd_len [10];
	logic                wr_ack_hold = 1'b0;  // stalls the write ack
	logic [31:0]         rng = 32'h12f8_bc9e;
	int                  errors = 0;
	int                  cycles = 0;

	sdram_fifo_bridge dut0 (.*);

	initial begin
		sys_clk = 1'b0;
		forever #50 sys_clk = ~sys_clk;
	end

	// ------------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------------
	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic logic [31:0] next_random();
		rng = xorshift(rng);
		return rng;
	endfunction

	// never written locations read back as a pattern of the full address
	function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] a);
		return a[15:0] ^ {8'h00, a[23:16]};
	endfunction

	function automatic logic [DATA_W-1:0] expected_word(input logic [ADDR_W-1:0] a);
		return ref_mem.exists(a) ? ref_mem[a] : fill_word(a);
	endfunction

	task automatic next_cycle();
		@(posedge sys_clk);
		#10;
	endtask

	task automatic check_value(input string name, input logic [31:0] exp,
	                           input logic [31:0] act);
		assert (act === exp) else begin
			$display("FAIL %0t %s expected %h got %h", $time, name, exp, act);
			errors++;
		end
	endtask

	// ------------------------------------------------------------------
	// SDRAM controller model
	// ------------------------------------------------------------------
	initial begin : sdram_write_model
		logic [ADDR_W-1:0] addr;
		logic [LEN_W-1:0]  len;
		forever begin
			next_cycle();
			if (sdram_wr_req_o) begin
				addr = sdram_wr_addr_o;
				len  = sdram_wr_len_o;
				check_value("sdram_wr_addr_o", exp_addr_q.pop_front(), addr);
				check_value("sdram_wr_len_o", exp_len_q.pop_front(), len);
				repeat (next_random() % 7) next_cycle();
				while (wr_ack_hold)
					next_cycle();
				sdram_wr_ack_i = 1'b1;
				next_cycle();  // past the ack edge, word 0 on the bus
				sdram_wr_ack_i = 1'b0;
				for (int i = 0; i < len; i++) begin
					sdram_mem[addr + ADDR_W'(i)] = sdram_wr_data_o;
					check_value("sdram_wr_data_o", exp_word_q.pop_front(), sdram_wr_data_o);
					next_cycle();
				end
			end
		end
	end

	initial begin : sdram_read_model
		logic [ADDR_W-1:0] addr;
		logic [ADDR_W-1:0] a;
		logic [LEN_W-1:0]  len;
		forever begin
			next_cycle();
			if (sdram_rd_req_o) begin
				addr = sdram_rd_addr_o;
				len  = sdram_rd_len_o;
				check_value("sdram_rd_addr_o", rd_exp_addr, addr);
				check_value("sdram_rd_len_o", rd_exp_len, len);
				repeat (next_random() % 7) next_cycle();
				sdram_rd_ack_i = 1'b1;
				next_cycle();
				sdram_rd_ack_i = 1'b0;
				for (int i = 0; i < len; i++) begin
					a = addr + ADDR_W'(i);
					repeat (next_random() % 3) next_cycle();  // valid gap
					sdram_rd_valid_i = 1'b1;
					sdram_rd_data_i  = sdram_mem.exists(a) ? sdram_mem[a] : fill_word(a);
					next_cycle();
					sdram_rd_valid_i = 1'b0;
				end
			end
		end
	end

	// ------------------------------------------------------------------
	// user side bursts
	// ------------------------------------------------------------------
	task automatic write_burst(input logic [ADDR_W-1:0] addr, input logic [LEN_W-1:0] len);
		logic [DATA_W-1:0] w;
		while (!wr_rdy_o)
			next_cycle();
		exp_addr_q.push_back(addr);
		exp_len_q.push_back(len);
		wr_req_i  = 1'b1;
		wr_addr_i = addr;
		wr_len_i  = len;
		for (int i = 0; i < len; i++) begin
			w = DATA_W'(next_random());
			wr_data_i = w;
			exp_word_q.push_back(w);
			ref_mem[addr + ADDR_W'(i)] = w;
			next_cycle();
			wr_req_i = 1'b0;
			if (i == 0)
				check_value("wr_rdy_o", 0, wr_rdy_o);  // low right after acceptance
		end
	endtask

	task automatic read_burst(input logic [ADDR_W-1:0] addr, input logic [LEN_W-1:0] len);
		logic [ADDR_W-1:0] a;
		while (!rd_rdy_o)
			next_cycle();
		rd_exp_addr = addr;
		rd_exp_len  = len;
		rd_req_i    = 1'b1;
		rd_addr_i   = addr;
		rd_len_i    = len;
		next_cycle();
		rd_req_i = 1'b0;
		while (!rd_valid_o) begin
			check_value("rd_rdy_o", 0, rd_rdy_o);
			next_cycle();
		end
		for (int i = 0; i < len; i++) begin
			a = addr + ADDR_W'(i);
			check_value("rd_valid_o", 1, rd_valid_o);  // one unbroken run
			check_value("rd_rdy_o", 0, rd_rdy_o);
			check_value("rd_data_o", expected_word(a), rd_data_o);
			next_cycle();
		end
		check_value("rd_valid_o", 0, rd_valid_o);
	endtask

	task automatic drain_writes();
		while (exp_word_q.size() != 0)
			next_cycle();
	endtask

	// ack held back, queue bursts until wr_rdy_o stays low
	task automatic fill_until_stall(input logic [ADDR_W-1:0] base,
	                                input logic [LEN_W-1:0] len, input int max_bursts);
		int waited;
		wr_ack_hold = 1'b1;
		for (int n = 0; n < max_bursts; n++) begin
			waited = 0;
			while (!wr_rdy_o && waited < 8) begin
				next_cycle();
				waited++;
			end
			if (!wr_rdy_o)
				break;
			write_burst(base + ADDR_W'(n * 64), len);
		end
		check_value("wr_rdy_o", 0, wr_rdy_o);
		wr_ack_hold = 1'b0;
		drain_writes();
	endtask

	task automatic finish_run();
		$display("errors: %0d in data checks, %0d in assertions", errors, dut0.u_chk.fail_cnt);
		if (errors == 0 && dut0.u_chk.fail_cnt == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	endtask

	// ------------------------------------------------------------------
	// run limit
	// ------------------------------------------------------------------
	always @(posedge sys_clk) begin
		cycles++;
		if (cycles == TIMEOUT_CYCLES) begin
			$display("timeout: run did not end within %0d cycles", TIMEOUT_CYCLES);
			$display("errors: %0d in data checks, %0d in assertions", errors, dut0.u_chk.fail_cnt);
			$display("Finished with errors");
			$finish;
		end
	end

	// ------------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------------
	initial begin : stimulus
		sys_rst_n        = 1'b0;
		init_end_i       = 1'b0;
		wr_req_i         = 1'b0;
		wr_addr_i        = '0;
		wr_len_i         = '0;
		wr_data_i        = '0;
		rd_req_i         = 1'b0;
		rd_addr_i        = '0;
		rd_len_i         = '0;
		sdram_wr_ack_i   = 1'b0;
		sdram_rd_ack_i   = 1'b0;
		sdram_rd_valid_i = 1'b0;
		sdram_rd_data_i  = '0;
		repeat (5) @(posedge sys_clk);
		#10 sys_rst_n = 1'b1;

		// all quiet until SDRAM init is done
		repeat (3) next_cycle();
		check_value("wr_rdy_o", 0, wr_rdy_o);
		check_value("rd_rdy_o", 0, rd_rdy_o);
		check_value("sdram_wr_req_o", 0, sdram_wr_req_o);
		check_value("sdram_rd_req_o", 0, sdram_rd_req_o);
		check_value("rd_valid_o", 0, rd_valid_o);
		init_end_i = 1'b1;
		next_cycle();
		check_value("wr_rdy_o", 1, wr_rdy_o);
		check_value("rd_rdy_o", 1, rd_rdy_o);

		// shortest and longest bursts, then random ones
		write_burst(24'h00_0100, 1);
		write_burst(24'h00_0200, 64);
		for (int i = 0; i < 10; i++) begin
			rnd_addr[i] = ADDR_W'(next_random() & 32'h003f_ffff);  // below the stall area
			rnd_len[i]  = LEN_W'(next_random() % MAX_BURST + 1);
			write_burst(rnd_addr[i], rnd_len[i]);
		end
		drain_writes();
		read_burst(24'h00_0100, 1);
		read_burst(24'h00_0200, 64);
		for (int i = 0; i < 10; i++)
			read_burst(rnd_addr[i], rnd_len[i]);

		// back-pressure by command fifo, then by tx room
		fill_until_stall(24'h40_0000, 2, 12);
		fill_until_stall(24'h50_0000, 64, 4);
		read_burst(24'h40_0000, 2);
		read_burst(24'h50_0040, 64);
		read_burst(24'hf0_0000, 16);  // never written
		finish_run();
	end

endmodule

`default_nettype wire

//--- sdram_fifo_bridge.f
hw/sdram_bridge_pkg.sv
hw/sync_fifo.sv
hw/wr_burst_engine.sv
hw/rd_burst_engine.sv
hw/sdram_fifo_bridge.sv
tb/sdram_fifo_bridge_checker.sv
tb/sdram_fifo_bridge_tb.sv

//--- Bender.yml
package:
  name: sdram_fifo_bridge

sources:
  - hw/sdram_bridge_pkg.sv
  - hw/sync_fifo.sv
  - hw/wr_burst_engine.sv
  - hw/rd_burst_engine.sv
  - hw/sdram_fifo_bridge.sv
  - target: test
    files:
      - tb/sdram_fifo_bridge_checker.sv
      - tb/sdram_fifo_bridge_tb.sv
